//--- deparser_pkg.sv
package deparser_pkg;

    // stream geometry
    localparam int DATA_W = 512;
    localparam int KEEP_W = DATA_W / 8;
    localparam int USER_W = 128;

    // action table
    localparam int TABLE_DEPTH    = 16;
    localparam int TABLE_ADDR_LSB = 120;
    localparam int MAX_SLOTS      = 10;

    // control header fields
    localparam int          MOD_ID_POS     = 368;
    localparam int          CTRL_FLAG_POS  = 320;
    localparam logic [15:0] CTRL_FLAG      = 16'hf2f1;
    localparam int          CTRL_INDEX_POS = 384;

    // phv layout
    localparam int NUM_CONT = 8;
    localparam int META_W   = 356;

    // container type codes in an action word
    localparam logic [1:0] CTYPE_NONE = 2'b00;
    localparam logic [1:0] CTYPE_2B   = 2'b01;
    localparam logic [1:0] CTYPE_4B   = 2'b10;
    localparam logic [1:0] CTYPE_6B   = 2'b11;

    // widest container, in bytes
    localparam int PATCH_MAX_BYTES = 6;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        logic [USER_W-1:0] user;
        logic              last;
    } axis_beat_t;

    typedef struct packed {
        logic [3:0] reserved;
        logic [5:0] offset;
        logic [1:0] ctype;
        logic [2:0] index;
        logic       valid;
    } deparse_action_t;

    typedef deparse_action_t [MAX_SLOTS-1:0] action_entry_t;

    typedef struct packed {
        logic [NUM_CONT-1:0][47:0] c6;
        logic [NUM_CONT-1:0][31:0] c4;
        logic [NUM_CONT-1:0][15:0] c2;
        logic [META_W-1:0]         meta;
    } phv_t;

    // value is left aligned, first byte on the wire in bits 47:40
    typedef struct packed {
        logic [47:0] value;
        logic [2:0]  len_bytes;
        logic [5:0]  offset;
    } patch_t;

endpackage

//--- cfg_loader.sv
`timescale 1ns/1ns

module cfg_loader #(
    parameter int DEPARSER_ID = 5
) (
    input  logic                        clk,
    input  logic                        aresetn,
    input  deparser_pkg::axis_beat_t    ctrl_beat,
    input  logic                        ctrl_valid,
    output logic                        tbl_wr_en,
    output logic [3:0]                  tbl_wr_addr,
    output deparser_pkg::action_entry_t tbl_wr_data
);

    typedef enum logic {
        C_IDLE,
        C_WRITE
    } state_t;

    state_t                      state;
    logic [3:0]                  wr_index;
    logic [2:0]                  mod_id;
    logic [15:0]                 ctrl_flag;
    logic                        is_header;
    deparser_pkg::action_entry_t entry_swapped;

    // only the low bits of the id byte are compared
    assign mod_id    = ctrl_beat.data[deparser_pkg::MOD_ID_POS +: 3];
    assign ctrl_flag = ctrl_beat.data[deparser_pkg::CTRL_FLAG_POS +: 16];
    assign is_header = ctrl_valid && (mod_id == 3'(DEPARSER_ID))
                       && (ctrl_flag == deparser_pkg::CTRL_FLAG);

    // byte 2i is the high byte of slot i
    always_comb begin
        for (int i = 0; i < deparser_pkg::MAX_SLOTS; i++) begin
            entry_swapped[i] = {ctrl_beat.data[16*i +: 8], ctrl_beat.data[16*i+8 +: 8]};
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= C_IDLE;
            wr_index    <= '0;
            tbl_wr_en   <= 1'b0;
            tbl_wr_addr <= '0;
        end else begin
            tbl_wr_en <= 1'b0;
            case (state)
                C_IDLE: begin
                    if (is_header) begin
                        wr_index <= ctrl_beat.data[deparser_pkg::CTRL_INDEX_POS +: 4];
                        if (!ctrl_beat.last) begin
                            state <= C_WRITE;
                        end
                    end
                end
                C_WRITE: begin
                    if (ctrl_valid) begin
                        tbl_wr_en   <= 1'b1;
                        tbl_wr_addr <= wr_index;
                        wr_index    <= wr_index + 4'd1;
                        if (ctrl_beat.last) begin
                            state <= C_IDLE;
                        end
                    end
                end
                default: state <= C_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == C_WRITE && ctrl_valid) begin
            tbl_wr_data <= entry_swapped;
        end
    end

    a_no_write_after_reset: assert property (
        @(posedge clk) $rose(aresetn) |-> (state == C_IDLE) && !tbl_wr_en
    ) else $error("table write active right after reset");

endmodule

//--- action_table.sv
`timescale 1ns/1ns

module action_table (
    input  logic                        clk,
    input  logic                        wr_en,
    input  logic [3:0]                  wr_addr,
    input  deparser_pkg::action_entry_t wr_data,
    input  logic [3:0]                  rd_addr,
    output deparser_pkg::action_entry_t entry
);

    deparser_pkg::action_entry_t mem [deparser_pkg::TABLE_DEPTH];

    // single write port from the control path
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, maps onto block ram
    always_ff @(posedge clk) begin
        entry <= mem[rd_addr];
    end

endmodule

//--- slot_extract.sv
`timescale 1ns/1ns

module slot_extract (
    input  logic                          clk,
    input  logic                          aresetn,
    input  logic                          ext_en,
    input  deparser_pkg::deparse_action_t action,
    input  deparser_pkg::phv_t            phv,
    output deparser_pkg::patch_t          patch
);

    deparser_pkg::patch_t sel;

    // pick the container and left align it, msb goes out first
    always_comb begin
        sel.offset    = action.offset;
        sel.value     = '0;
        sel.len_bytes = 3'd0;
        if (action.valid) begin
            case (action.ctype)
                deparser_pkg::CTYPE_2B: begin
                    sel.value     = {phv.c2[action.index], 32'h0};
                    sel.len_bytes = 3'd2;
                end
                deparser_pkg::CTYPE_4B: begin
                    sel.value     = {phv.c4[action.index], 16'h0};
                    sel.len_bytes = 3'd4;
                end
                deparser_pkg::CTYPE_6B: begin
                    sel.value     = phv.c6[action.index];
                    sel.len_bytes = 3'd6;
                end
                default: begin
                    // type none leaves length at zero
                    sel.len_bytes = 3'd0;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            patch <= '0;
        end else if (ext_en) begin
            patch <= sel;
        end
    end

endmodule

//--- header_rewriter.sv
`timescale 1ns/1ns

module header_rewriter #(
    parameter int NUM_SLOTS = 10
) (
    input  logic                     clk,
    input  logic                     aresetn,
    input  logic                     cap_en,
    input  logic                     patch_en,
    input  deparser_pkg::axis_beat_t beat_in,
    input  deparser_pkg::phv_t       phv_in,
    input  deparser_pkg::patch_t     patches [NUM_SLOTS],
    output deparser_pkg::axis_beat_t hdr_beat,
    output deparser_pkg::phv_t       phv_held,
    output logic [3:0]               tbl_addr
);

    logic [deparser_pkg::DATA_W-1:0] patched;

    assign tbl_addr = hdr_beat.data[deparser_pkg::TABLE_ADDR_LSB +: 4];

    // first byte lands on the lowest lane, later slots overwrite earlier ones
    always_comb begin
        int lane;
        patched = hdr_beat.data;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            for (int j = 0; j < deparser_pkg::PATCH_MAX_BYTES; j++) begin
                lane = int'(patches[s].offset) + j;
                if (j < int'(patches[s].len_bytes) && lane < deparser_pkg::KEEP_W) begin
                    patched[lane*8 +: 8] = patches[s].value[47-8*j -: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            hdr_beat <= '0;
        end else if (cap_en) begin
            hdr_beat <= beat_in;
        end else if (patch_en) begin
            hdr_beat.data <= patched;
        end
    end

    always_ff @(posedge clk) begin
        if (cap_en) begin
            phv_held <= phv_in;
        end
    end

endmodule

//--- deparse_fsm.sv
`timescale 1ns/1ns

module deparse_fsm (
    input  logic clk,
    input  logic aresetn,
    input  logic pkt_empty,
    input  logic phv_empty,
    input  logic pkt_last,
    input  logic hdr_last,
    input  logic out_ready,
    output logic pkt_rd_en,
    output logic phv_rd_en,
    output logic cap_en,
    output logic ext_en,
    output logic patch_en,
    output logic out_valid,
    output logic pass
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_EXTRACT,
        S_PATCH,
        S_EMIT,
        S_PASS
    } state_t;

    state_t state;
    state_t state_next;
    logic   hdr_valid;
    logic   start;
    logic   hdr_xfer;
    logic   pass_xfer;

    assign start     = (state == S_IDLE) && !pkt_empty && !phv_empty;
    assign hdr_xfer  = (state == S_EMIT) && hdr_valid && out_ready;
    assign pass_xfer = (state == S_PASS) && !pkt_empty && out_ready;

    // fall-through fifos, a beat is consumed whenever rd_en is high
    assign pkt_rd_en = start || pass_xfer;
    assign phv_rd_en = start;
    assign cap_en    = start;
    assign ext_en    = (state == S_EXTRACT);
    assign patch_en  = (state == S_PATCH);
    assign pass      = (state == S_PASS);
    assign out_valid = pass ? !pkt_empty : hdr_valid;

    always_comb begin
        state_next = state;
        case (state)
            S_IDLE: begin
                if (start) begin
                    state_next = S_LOOKUP;
                end
            end
            S_LOOKUP:  state_next = S_EXTRACT;
            S_EXTRACT: state_next = S_PATCH;
            S_PATCH:   state_next = S_EMIT;
            S_EMIT: begin
                if (hdr_xfer) begin
                    state_next = hdr_last ? S_IDLE : S_PASS;
                end
            end
            S_PASS: begin
                if (pass_xfer && pkt_last) begin
                    state_next = S_IDLE;
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

    // header valid comes one cycle into emit, once the patched beat has settled
    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            state     <= S_IDLE;
            hdr_valid <= 1'b0;
        end else begin
            state     <= state_next;
            hdr_valid <= (state == S_EMIT) && !hdr_xfer;
        end
    end

    a_no_read_when_empty: assert property (
        @(posedge clk) disable iff (!aresetn) pkt_rd_en |-> !pkt_empty
    ) else $error("packet fifo read while empty");

    a_emit_holds: assert property (
        @(posedge clk) disable iff (!aresetn)
        (state == S_EMIT) && out_valid && !out_ready |=> out_valid
    ) else $error("header beat dropped under back-pressure");

endmodule

//--- deparser_top.sv
`timescale 1ns/1ns

module deparser_top #(
    parameter int DEPARSER_ID = 5,
    parameter int NUM_SLOTS   = 10
) (
    input  logic                     clk,
    input  logic                     aresetn,
    input  deparser_pkg::axis_beat_t pkt_beat,
    input  logic                     pkt_empty,
    output logic                     pkt_rd_en,
    input  deparser_pkg::phv_t       phv_in,
    input  logic                     phv_empty,
    output logic                     phv_rd_en,
    output deparser_pkg::axis_beat_t out_beat,
    output logic                     out_valid,
    input  logic                     out_ready,
    input  deparser_pkg::axis_beat_t ctrl_beat,
    input  logic                     ctrl_valid
);

    logic                        tbl_wr_en;
    logic [3:0]                  tbl_wr_addr;
    deparser_pkg::action_entry_t tbl_wr_data;
    logic [3:0]                  tbl_addr;
    deparser_pkg::action_entry_t entry;
    deparser_pkg::phv_t          phv_held;
    deparser_pkg::patch_t        patches [NUM_SLOTS];
    deparser_pkg::axis_beat_t    hdr_beat;
    logic                        cap_en;
    logic                        ext_en;
    logic                        patch_en;
    logic                        pass;

    cfg_loader #(
        .DEPARSER_ID(DEPARSER_ID)
    ) i_cfg_loader (
        .clk        (clk),
        .aresetn    (aresetn),
        .ctrl_beat  (ctrl_beat),
        .ctrl_valid (ctrl_valid),
        .tbl_wr_en  (tbl_wr_en),
        .tbl_wr_addr(tbl_wr_addr),
        .tbl_wr_data(tbl_wr_data)
    );

    action_table i_action_table (
        .clk    (clk),
        .wr_en  (tbl_wr_en),
        .wr_addr(tbl_wr_addr),
        .wr_data(tbl_wr_data),
        .rd_addr(tbl_addr),
        .entry  (entry)
    );

    for (genvar g = 0; g < NUM_SLOTS; g++) begin : g_slot
        slot_extract i_slot_extract (
            .clk    (clk),
            .aresetn(aresetn),
            .ext_en (ext_en),
            .action (entry[g]),
            .phv    (phv_held),
            .patch  (patches[g])
        );
    end

    header_rewriter #(
        .NUM_SLOTS(NUM_SLOTS)
    ) i_header_rewriter (
        .clk     (clk),
        .aresetn (aresetn),
        .cap_en  (cap_en),
        .patch_en(patch_en),
        .beat_in (pkt_beat),
        .phv_in  (phv_in),
        .patches (patches),
        .hdr_beat(hdr_beat),
        .phv_held(phv_held),
        .tbl_addr(tbl_addr)
    );

    deparse_fsm i_deparse_fsm (
        .clk      (clk),
        .aresetn  (aresetn),
        .pkt_empty(pkt_empty),
        .phv_empty(phv_empty),
        .pkt_last (pkt_beat.last),
        .hdr_last (hdr_beat.last),
        .out_ready(out_ready),
        .pkt_rd_en(pkt_rd_en),
        .phv_rd_en(phv_rd_en),
        .cap_en   (cap_en),
        .ext_en   (ext_en),
        .patch_en (patch_en),
        .out_valid(out_valid),
        .pass     (pass)
    );

    // body beats go straight from the fifo head
    assign out_beat = pass ? pkt_beat : hdr_beat;

endmodule

//--- tb_deparser.sv
`timescale 1ns/1ns

module tb_deparser;

    localparam int DEPARSER_ID = 5;
    // six short tests of a few dozen cycles each leave a wide margin
    localparam int MAX_CYCLES = 4000;

    logic                        clk = 1'b0;
    logic                        aresetn;
    deparser_pkg::axis_beat_t    pkt_beat;
    logic                        pkt_empty;
    logic                        pkt_rd_en;
    deparser_pkg::phv_t          phv_in;
    logic                        phv_empty;
    logic                        phv_rd_en;
    deparser_pkg::axis_beat_t    out_beat;
    logic                        out_valid;
    logic                        out_ready;
    deparser_pkg::axis_beat_t    ctrl_beat;
    logic                        ctrl_valid;

    deparser_pkg::axis_beat_t    pkt_q [$];
    deparser_pkg::phv_t          phv_q [$];
    deparser_pkg::axis_beat_t    exp_q [$];
    deparser_pkg::action_entry_t model [deparser_pkg::TABLE_DEPTH];
    deparser_pkg::action_entry_t ctrl_ents [4];
    string                       cur_test;
    int                          errors = 0;
    int                          test_err_start;
    int                          tests_run = 0;
    int                          tests_failed = 0;
    int                          cycles = 0;
    bit                          bp_on = 1'b0;

    deparser_top #(
        .DEPARSER_ID(DEPARSER_ID),
        .NUM_SLOTS  (deparser_pkg::MAX_SLOTS)
    ) i_deparser_top (
        .clk       (clk),
        .aresetn   (aresetn),
        .pkt_beat  (pkt_beat),
        .pkt_empty (pkt_empty),
        .pkt_rd_en (pkt_rd_en),
        .phv_in    (phv_in),
        .phv_empty (phv_empty),
        .phv_rd_en (phv_rd_en),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .ctrl_beat (ctrl_beat),
        .ctrl_valid(ctrl_valid)
    );

    always #20 clk = ~clk;

    // container bytes go out msb first from lane offset upward
    function automatic deparser_pkg::axis_beat_t apply_entry(
        deparser_pkg::axis_beat_t beat, deparser_pkg::phv_t phv,
        deparser_pkg::action_entry_t ent);
        deparser_pkg::axis_beat_t        res;
        deparser_pkg::deparse_action_t   a;
        logic [47:0]                     cont;
        int                              len;
        int                              lane;
        res = beat;
        for (int s = 0; s < deparser_pkg::MAX_SLOTS; s++) begin
            a    = ent[s];
            cont = '0;
            len  = 0;
            if (a.valid) begin
                case (a.ctype)
                    2'b01: begin
                        cont = 48'(phv.c2[a.index]);
                        len  = 2;
                    end
                    2'b10: begin
                        cont = 48'(phv.c4[a.index]);
                        len  = 4;
                    end
                    2'b11: begin
                        cont = phv.c6[a.index];
                        len  = 6;
                    end
                    default: len = 0;
                endcase
            end
            for (int j = 0; j < len; j++) begin
                lane = int'(a.offset) + j;
                if (lane < deparser_pkg::KEEP_W) begin
                    res.data[lane*8 +: 8] = 8'(cont >> (8 * (len - 1 - j)));
                end
            end
        end
        return res;
    endfunction

    function automatic deparser_pkg::deparse_action_t mk_action(
        int off, logic [1:0] ctype, int idx, bit valid);
        deparser_pkg::deparse_action_t a;
        a.reserved = 4'h0;
        a.offset   = 6'(off);
        a.ctype    = ctype;
        a.index    = 3'(idx);
        a.valid    = valid;
        return a;
    endfunction

    function automatic deparser_pkg::action_entry_t random_entry();
        deparser_pkg::action_entry_t e;
        for (int i = 0; i < deparser_pkg::MAX_SLOTS; i++) begin
            e[i] = 16'($urandom);
        end
        return e;
    endfunction

    function automatic deparser_pkg::axis_beat_t random_beat();
        deparser_pkg::axis_beat_t b;
        for (int i = 0; i < deparser_pkg::DATA_W / 32; i++) begin
            b.data[32*i +: 32] = $urandom;
        end
        b.keep = {$urandom, $urandom};
        b.user = {$urandom, $urandom, $urandom, $urandom};
        b.last = 1'b0;
        return b;
    endfunction

    function automatic deparser_pkg::phv_t random_phv();
        logic [1151:0] raw;
        for (int i = 0; i < 36; i++) begin
            raw[32*i +: 32] = $urandom;
        end
        return deparser_pkg::phv_t'(raw[$bits(deparser_pkg::phv_t)-1:0]);
    endfunction

    // header beat followed by one beat per entry
    task automatic send_ctrl(input logic [7:0] id, input logic [15:0] flag,
                             input int start, input int n);
        deparser_pkg::axis_beat_t b;
        logic                     match;
        match = (id[2:0] == 3'(DEPARSER_ID)) && (flag == deparser_pkg::CTRL_FLAG);
        b = '0;
        b.data[deparser_pkg::MOD_ID_POS +: 8]     = id;
        b.data[deparser_pkg::CTRL_FLAG_POS +: 16] = flag;
        b.data[deparser_pkg::CTRL_INDEX_POS +: 8] = 8'(start);
        b.last = (n == 0);
        @(posedge clk);
        ctrl_beat  <= b;
        ctrl_valid <= 1'b1;
        for (int k = 0; k < n; k++) begin
            b = '0;
            for (int i = 0; i < deparser_pkg::MAX_SLOTS; i++) begin
                b.data[16*i +: 8]   = ctrl_ents[k][i][15:8];
                b.data[16*i+8 +: 8] = ctrl_ents[k][i][7:0];
            end
            b.last = (k == n - 1);
            @(posedge clk);
            ctrl_beat <= b;
            // the model follows only accepted streams
            if (match) begin
                model[(start + k) % deparser_pkg::TABLE_DEPTH] = ctrl_ents[k];
            end
        end
        @(posedge clk);
        ctrl_valid <= 1'b0;
        ctrl_beat  <= '0;
        // last write lands two edges after its beat
        repeat (3) @(posedge clk);
    endtask

    task automatic send_packet(input int addr, input int nbeats, input bit unchanged);
        deparser_pkg::axis_beat_t b;
        deparser_pkg::phv_t       p;
        p = random_phv();
        @(negedge clk);
        phv_q.push_back(p);
        for (int k = 0; k < nbeats; k++) begin
            b = random_beat();
            b.last = (k == nbeats - 1);
            if (k == 0) begin
                b.data[deparser_pkg::TABLE_ADDR_LSB +: 4] = 4'(addr);
                exp_q.push_back(unchanged ? b : apply_entry(b, p, model[addr]));
            end else begin
                exp_q.push_back(b);
            end
            pkt_q.push_back(b);
        end
    endtask

    task automatic begin_test(input string name);
        cur_test       = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        // a few more edges so a stray extra beat is caught
        repeat (4) @(posedge clk);
        tests_run++;
        if (errors > test_err_start) begin
            tests_failed++;
            $display("test %s: FAIL (%0d errors)", cur_test, errors - test_err_start);
        end else begin
            $display("test %s: pass", cur_test);
        end
    endtask

    // fall-through fifo models pop on the edge where rd_en is seen high
    always @(posedge clk) begin
        if (pkt_rd_en && pkt_empty) begin
            errors++;
            $display("packet FIFO read while empty in test %s", cur_test);
        end
        if (phv_rd_en && phv_empty) begin
            errors++;
            $display("PHV FIFO read while empty in test %s", cur_test);
        end
        if (pkt_rd_en && pkt_q.size() != 0) begin
            void'(pkt_q.pop_front());
        end
        if (phv_rd_en && phv_q.size() != 0) begin
            void'(phv_q.pop_front());
        end
        pkt_empty <= (pkt_q.size() == 0);
        phv_empty <= (phv_q.size() == 0);
        if (pkt_q.size() != 0) begin
            pkt_beat <= pkt_q[0];
        end
        if (phv_q.size() != 0) begin
            phv_in <= phv_q[0];
        end
        out_ready <= bp_on ? 1'($urandom) : 1'b1;
    end

    always @(posedge clk) begin
        deparser_pkg::axis_beat_t exp_beat;
        if (aresetn && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected output beat in test %s: %h", cur_test, out_beat);
            end else begin
                exp_beat = exp_q.pop_front();
                if (out_beat !== exp_beat) begin
                    errors++;
                    $display("ERROR %s: expected %h actual %h", cur_test, exp_beat, out_beat);
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles with %0d beats outstanding",
                     cycles, exp_q.size());
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h85af));
        aresetn    = 1'b0;
        pkt_beat   = '0;
        pkt_empty  = 1'b1;
        phv_in     = '0;
        phv_empty  = 1'b1;
        out_ready  = 1'b0;
        ctrl_beat  = '0;
        ctrl_valid = 1'b0;
        repeat (10) @(posedge clk);
        aresetn <= 1'b1;
        repeat (2) @(posedge clk);

        begin_test("single_beat");
        ctrl_ents[0]    = '0;
        ctrl_ents[0][0] = mk_action(0, 2'b01, 2, 1'b1);
        ctrl_ents[0][1] = mk_action(10, 2'b10, 5, 1'b1);
        ctrl_ents[0][2] = mk_action(20, 2'b11, 7, 1'b1);
        ctrl_ents[0][3] = mk_action(62, 2'b01, 0, 1'b1);
        // higher slot wins where it overlaps slot 2
        ctrl_ents[0][4] = mk_action(23, 2'b11, 1, 1'b1);
        send_ctrl(8'h05, deparser_pkg::CTRL_FLAG, 3, 1);
        send_packet(3, 1, 1'b0);
        end_test();

        begin_test("multi_beat");
        send_packet(3, 4, 1'b0);
        end_test();

        begin_test("inactive_slots");
        ctrl_ents[0]    = '0;
        ctrl_ents[0][0] = mk_action(4, 2'b11, 1, 1'b0);
        ctrl_ents[0][1] = mk_action(30, 2'b00, 3, 1'b1);
        send_ctrl(8'h05, deparser_pkg::CTRL_FLAG, 4, 1);
        send_packet(4, 2, 1'b1);
        end_test();

        begin_test("ctrl_filter");
        ctrl_ents[0] = random_entry();
        send_ctrl(8'h06, deparser_pkg::CTRL_FLAG, 3, 1);
        send_ctrl(8'h05, 16'hf2f0, 3, 1);
        send_packet(3, 1, 1'b0);
        end_test();

        begin_test("multi_entry");
        for (int k = 0; k < 3; k++) begin
            ctrl_ents[k] = random_entry();
        end
        send_ctrl(8'h05, deparser_pkg::CTRL_FLAG, 8, 3);
        send_packet(8, 1, 1'b0);
        send_packet(10, 2, 1'b0);
        end_test();

        begin_test("backpressure");
        bp_on = 1'b1;
        send_packet(8, 1, 1'b0);
        send_packet(9, 3, 1'b0);
        send_packet(10, 2, 1'b0);
        end_test();
        bp_on = 1'b0;

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- deparser.f
deparser_pkg.sv
cfg_loader.sv
action_table.sv
slot_extract.sv
header_rewriter.sv
deparse_fsm.sv
deparser_top.sv
tb_deparser.sv

//--- Bender.yml
package:
  name: deparser

sources:
  - deparser_pkg.sv
  - cfg_loader.sv
  - action_table.sv
  - slot_extract.sv
  - header_rewriter.sv
  - deparse_fsm.sv
  - deparser_top.sv
  - target: test
    files:
      - tb_deparser.sv
